// ==== verilog/clint_pkg.sv ====
`default_nettype none

package clint_pkg;

    // bus widths
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = 4;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // window is 64 KiB
    localparam int WINDOW_BITS = 16;

    localparam logic [WINDOW_BITS-1:0] OFF_MSIP        = 16'h0000;
    localparam logic [WINDOW_BITS-1:0] OFF_MTIMECMP_LO = 16'h4000;
    localparam logic [WINDOW_BITS-1:0] OFF_MTIMECMP_HI = 16'h4004;
    localparam logic [WINDOW_BITS-1:0] OFF_MTIME_LO    = 16'hBFF8;
    localparam logic [WINDOW_BITS-1:0] OFF_MTIME_HI    = 16'hBFFC;

    typedef enum logic [2:0] {
        MSIP,
        CMP_LO,
        CMP_HI,
        TIME_LO,
        TIME_HI,
        NONE
    } clint_reg_e;

    // front end to decode
    typedef struct packed {
        logic                  valid;   // one-cycle strobe
        logic                  write;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_DATA_W-1:0] wdata;
        logic [AXI_STRB_W-1:0] wstrb;
    } axil_req_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic                  write;
        clint_reg_e            reg_sel;
        logic [1:0]            err;     // response code, OKAY when mapped
        logic [AXI_DATA_W-1:0] wdata;
        logic [AXI_STRB_W-1:0] wstrb;
    } clint_sel_t;

    // execute to result
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            resp;
    } clint_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/clint_axil_front.sv ====
`default_nettype none

module clint_axil_front (
    input  wire logic                                clk,
    input  wire logic                                rst_n,

    // AR
    input  wire logic [clint_pkg::AXI_ADDR_W-1:0]    araddr,
    input  wire logic                                arvalid,
    output logic                                     arready,

    // AW
    input  wire logic [clint_pkg::AXI_ADDR_W-1:0]    awaddr,
    input  wire logic                                awvalid,
    output logic                                     awready,

    // W
    input  wire logic [clint_pkg::AXI_DATA_W-1:0]    wdata,
    input  wire logic [clint_pkg::AXI_STRB_W-1:0]    wstrb,
    input  wire logic                                wvalid,
    output logic                                     wready,

    output clint_pkg::axil_req_t                     req,
    input  wire logic                                done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_W,
        ST_ISSUED,
        ST_WAIT_DONE
    } state_e;

    state_e state;

    logic                             ar_hs;
    logic                             aw_hs;
    logic                             w_hs;

    logic                             write_q;
    logic [clint_pkg::AXI_ADDR_W-1:0] addr_q;
    logic [clint_pkg::AXI_DATA_W-1:0] wdata_q;
    logic [clint_pkg::AXI_STRB_W-1:0] wstrb_q;

    assign arready = (state == ST_IDLE);
    // read wins when both address channels show up together
    assign awready = (state == ST_IDLE) && !arvalid;
    assign wready  = (state == ST_WAIT_W);

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ar_hs) begin
                        state <= ST_ISSUED;
                    end else if (aw_hs) begin
                        state <= ST_WAIT_W;
                    end
                end
                ST_WAIT_W: begin
                    if (w_hs) begin
                        state <= ST_ISSUED;
                    end
                end
                ST_ISSUED: begin
                    state <= ST_WAIT_DONE;   // request strobe lasts one cycle
                end
                ST_WAIT_DONE: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q  <= araddr;
            write_q <= 1'b0;
        end else if (aw_hs) begin
            addr_q  <= awaddr;
            write_q <= 1'b1;
        end
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    assign req.valid = (state == ST_ISSUED);
    assign req.write = write_q;
    assign req.addr  = addr_q;
    assign req.wdata = wdata_q;
    assign req.wstrb = wstrb_q;

endmodule

`default_nettype wire

// ==== verilog/clint_decode.sv ====
`default_nettype none

module clint_decode #(
    parameter logic [clint_pkg::AXI_ADDR_W-1:0] BASE_ADDR = 32'h0200_0000
) (
    input  wire clint_pkg::axil_req_t req,
    output clint_pkg::clint_sel_t     sel
);

    localparam int AW = clint_pkg::AXI_ADDR_W;
    localparam int WB = clint_pkg::WINDOW_BITS;

    logic [WB-1:0] offset;
    logic          hit;
    logic          misaligned;

    assign offset     = req.addr[WB-1:0];
    assign hit        = (req.addr[AW-1:WB] == BASE_ADDR[AW-1:WB]);
    assign misaligned = (req.addr[1:0] != 2'b00);

    always_comb begin
        sel.valid   = req.valid;
        sel.write   = req.write;
        sel.wdata   = req.wdata;
        sel.wstrb   = req.wstrb;
        sel.reg_sel = clint_pkg::NONE;
        sel.err     = clint_pkg::RESP_OKAY;

        if (!hit) begin
            sel.err = clint_pkg::RESP_DECERR;   // outside the window
        end else if (misaligned) begin
            sel.err = clint_pkg::RESP_SLVERR;
        end else begin
            case (offset)
                clint_pkg::OFF_MSIP: begin
                    sel.reg_sel = clint_pkg::MSIP;
                end
                clint_pkg::OFF_MTIMECMP_LO: begin
                    sel.reg_sel = clint_pkg::CMP_LO;
                end
                clint_pkg::OFF_MTIMECMP_HI: begin
                    sel.reg_sel = clint_pkg::CMP_HI;
                end
                clint_pkg::OFF_MTIME_LO: begin
                    sel.reg_sel = clint_pkg::TIME_LO;
                end
                clint_pkg::OFF_MTIME_HI: begin
                    sel.reg_sel = clint_pkg::TIME_HI;
                end
                default: begin
                    sel.err = clint_pkg::RESP_SLVERR;   // hole in the map
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/clint_exec.sv ====
`default_nettype none

module clint_exec #(
    parameter int TICK_DIV = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire clint_pkg::clint_sel_t sel,
    output clint_pkg::clint_rsp_t     rsp,
    output logic                      timer_irq,
    output logic                      soft_irq
);

    localparam int DW    = clint_pkg::AXI_DATA_W;
    localparam int SW    = clint_pkg::AXI_STRB_W;
    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] presc;
    logic             tick;

    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic             msip;

    logic             wr_en;
    logic [DW-1:0]    rd_val;

    logic             rsp_valid;
    logic             rsp_write;
    logic [DW-1:0]    rsp_rdata;
    logic [1:0]       rsp_resp;

    // byte-wise merge under the write strobes
    function automatic logic [DW-1:0] merge(
        input logic [DW-1:0] old_val,
        input logic [DW-1:0] new_val,
        input logic [SW-1:0] strb
    );
        logic [DW-1:0] res;
        res = old_val;
        for (int i = 0; i < SW; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en = sel.valid && sel.write && (sel.err == clint_pkg::RESP_OKAY);
    assign tick  = (presc == DIV_W'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc <= '0;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_en && sel.reg_sel == clint_pkg::TIME_LO) begin
            mtime[31:0] <= merge(mtime[31:0], sel.wdata, sel.wstrb);   // beats the tick
        end else if (wr_en && sel.reg_sel == clint_pkg::TIME_HI) begin
            mtime[63:32] <= merge(mtime[63:32], sel.wdata, sel.wstrb);
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;   // no timer irq out of reset
            msip     <= 1'b0;
        end else if (wr_en) begin
            case (sel.reg_sel)
                clint_pkg::CMP_LO: mtimecmp[31:0]  <= merge(mtimecmp[31:0], sel.wdata, sel.wstrb);
                clint_pkg::CMP_HI: mtimecmp[63:32] <= merge(mtimecmp[63:32], sel.wdata, sel.wstrb);
                clint_pkg::MSIP: begin
                    if (sel.wstrb[0]) begin
                        msip <= sel.wdata[0];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (sel.reg_sel)
            clint_pkg::MSIP:    rd_val = {{(DW-1){1'b0}}, msip};
            clint_pkg::CMP_LO:  rd_val = mtimecmp[31:0];
            clint_pkg::CMP_HI:  rd_val = mtimecmp[63:32];
            clint_pkg::TIME_LO: rd_val = mtime[31:0];
            clint_pkg::TIME_HI: rd_val = mtime[63:32];
            default:            rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel.valid) begin
            rsp_write <= sel.write;
            rsp_resp  <= sel.err;
            rsp_rdata <= (sel.err == clint_pkg::RESP_OKAY) ? rd_val : '0;
        end
    end

    assign rsp.valid = rsp_valid;
    assign rsp.write = rsp_write;
    assign rsp.rdata = rsp_rdata;
    assign rsp.resp  = rsp_resp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    assign soft_irq = msip;

endmodule

`default_nettype wire

// ==== verilog/clint_result.sv ====
`default_nettype none

module clint_result (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire clint_pkg::clint_rsp_t             rsp,

    // R
    output logic [clint_pkg::AXI_DATA_W-1:0]       rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  wire logic                              rready,

    // B
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  wire logic                              bready,

    output logic                                   done
);

    logic r_hs;
    logic b_hs;

    assign r_hs = rvalid && rready;
    assign b_hs = bvalid && bready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            done   <= 1'b0;
        end else begin
            if (rsp.valid && !rsp.write) begin
                rvalid <= 1'b1;
            end else if (r_hs) begin
                rvalid <= 1'b0;
            end
            if (rsp.valid && rsp.write) begin
                bvalid <= 1'b1;
            end else if (b_hs) begin
                bvalid <= 1'b0;
            end
            done <= r_hs || b_hs;   // frees the front end
        end
    end

    // held steady while the master stalls
    always_ff @(posedge clk) begin
        if (rsp.valid && !rsp.write) begin
            rdata <= rsp.rdata;
            rresp <= rsp.resp;
        end
        if (rsp.valid && rsp.write) begin
            bresp <= rsp.resp;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/clint_top.sv ====
`default_nettype none

module clint_top #(
    parameter logic [clint_pkg::AXI_ADDR_W-1:0] BASE_ADDR = 32'h0200_0000,
    parameter int                               TICK_DIV  = 4
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // AR
    input  wire logic [clint_pkg::AXI_ADDR_W-1:0]  araddr,
    input  wire logic                              arvalid,
    output logic                                   arready,
    // R
    output logic [clint_pkg::AXI_DATA_W-1:0]       rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  wire logic                              rready,
    // AW
    input  wire logic [clint_pkg::AXI_ADDR_W-1:0]  awaddr,
    input  wire logic                              awvalid,
    output logic                                   awready,
    // W
    input  wire logic [clint_pkg::AXI_DATA_W-1:0]  wdata,
    input  wire logic [clint_pkg::AXI_STRB_W-1:0]  wstrb,
    input  wire logic                              wvalid,
    output logic                                   wready,
    // B
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  wire logic                              bready,

    output logic                                   timer_irq,
    output logic                                   soft_irq
);

    clint_pkg::axil_req_t  req;
    clint_pkg::clint_sel_t sel;
    clint_pkg::clint_rsp_t rsp;
    logic                  done;

    clint_axil_front front_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .req     (req),
        .done    (done)
    );

    clint_decode #(
        .BASE_ADDR (BASE_ADDR)
    ) decode_i (
        .req (req),
        .sel (sel)
    );

    clint_exec #(
        .TICK_DIV (TICK_DIV)
    ) exec_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (sel),
        .rsp       (rsp),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    clint_result result_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .rsp    (rsp),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .done   (done)
    );

endmodule

`default_nettype wire

// ==== testbench/clint_tb.sv ====
`default_nettype none

module clint_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] BASE = 32'h0200_0000;
    localparam int TICK = 4;
    localparam int WAIT_LIMIT = 100;

    logic        clk;
    logic        rst_n;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        timer_irq;
    logic        soft_irq;
    int          cycles;

    clint_top #(
        .BASE_ADDR (BASE),
        .TICK_DIV  (TICK)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;   // time base for the mtime test
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] reg_addr(input logic [15:0] off);
        return {BASE[31:16], off};
    endfunction

    // stall holds rready low that many cycles once rvalid is up
    task automatic axi_read(input logic [31:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        for (n = 0; !arready; n++) begin
            if (n == WAIT_LIMIT) abort_run("timeout waiting for arready");
            next_cycle();
        end
        next_cycle();   // AR handshake
        arvalid = 1'b0;
        for (n = 0; !rvalid; n++) begin
            if (n == WAIT_LIMIT) abort_run("timeout waiting for rvalid");
            next_cycle();
        end
        check("read latency", 2, n);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < stall; i++) begin
            next_cycle();
            check("stall rvalid", 1, 32'(rvalid));
            check("stall rdata", data, rdata);
            check("stall rresp", 32'(resp), 32'(rresp));
            check("stall arready", 0, 32'(arready));
            check("stall read awready", 0, 32'(awready));
            check("stall read wready", 0, 32'(wready));
        end
        rready = 1'b1;
        next_cycle();   // R handshake
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall,
                             output logic [1:0] resp);
        int n;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        for (n = 0; !awready; n++) begin
            if (n == WAIT_LIMIT) abort_run("timeout waiting for awready");
            next_cycle();
        end
        next_cycle();   // AW handshake
        awvalid = 1'b0;
        for (n = 0; !wready; n++) begin
            if (n == WAIT_LIMIT) abort_run("timeout waiting for wready");
            next_cycle();
        end
        next_cycle();   // W handshake
        wvalid = 1'b0;
        for (n = 0; !bvalid; n++) begin
            if (n == WAIT_LIMIT) abort_run("timeout waiting for bvalid");
            next_cycle();
        end
        check("write latency", 2, n);
        resp = bresp;
        for (int i = 0; i < stall; i++) begin
            next_cycle();
            check("stall bvalid", 1, 32'(bvalid));
            check("stall bresp", 32'(resp), 32'(bresp));
            check("stall awready", 0, 32'(awready));
            check("stall wready", 0, 32'(wready));
        end
        bready = 1'b1;
        next_cycle();   // B handshake
        bready = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [15:0] off,
                               input logic [31:0] expected);
        logic [31:0] d;
        logic [1:0]  r;
        axi_read(reg_addr(off), 0, d, r);
        check({name, " resp"}, 32'(clint_pkg::RESP_OKAY), 32'(r));
        check(name, expected, d);
    endtask

    task automatic write_reg(input logic [15:0] off, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [1:0] r;
        axi_write(reg_addr(off), data, strb, 0, r);
        check("write resp", 32'(clint_pkg::RESP_OKAY), 32'(r));
    endtask

    task automatic reset_state;
        check("reset arready", 1, 32'(arready));
        check("reset awready", 1, 32'(awready));
        check("reset wready", 0, 32'(wready));
        check("reset rvalid", 0, 32'(rvalid));
        check("reset bvalid", 0, 32'(bvalid));
        check("reset timer_irq", 0, 32'(timer_irq));
        check("reset soft_irq", 0, 32'(soft_irq));
        read_expect("reset msip", clint_pkg::OFF_MSIP, 0);
        read_expect("reset mtimecmp_lo", clint_pkg::OFF_MTIMECMP_LO, 32'hffff_ffff);
        read_expect("reset mtimecmp_hi", clint_pkg::OFF_MTIMECMP_HI, 32'hffff_ffff);
    endtask

    task automatic msip_and_strobes;
        logic [31:0] old_v;
        logic [31:0] new_v;
        logic [31:0] mask;
        old_v = $urandom;
        new_v = $urandom;
        write_reg(clint_pkg::OFF_MSIP, 1, 4'hf);
        check("msip set soft_irq", 1, 32'(soft_irq));
        read_expect("msip set", clint_pkg::OFF_MSIP, 1);
        write_reg(clint_pkg::OFF_MSIP, 0, 4'hf);
        check("msip clear soft_irq", 0, 32'(soft_irq));
        write_reg(clint_pkg::OFF_MTIMECMP_LO, old_v, 4'hf);
        write_reg(clint_pkg::OFF_MTIMECMP_LO, new_v, 4'b0101);
        mask = 32'h00ff_00ff;   // bytes 0 and 2
        read_expect("strobe merge", clint_pkg::OFF_MTIMECMP_LO,
                    (new_v & mask) | (old_v & ~mask));
        write_reg(clint_pkg::OFF_MTIMECMP_LO, 32'hffff_ffff, 4'hf);
    endtask

    task automatic mtime_counting;
        int          base_v;
        int          t0;
        int          elapsed;
        int          lo_b;
        int          hi_b;
        logic [31:0] d;
        logic [1:0]  r;
        base_v = int'($urandom & 32'h0fff_ffff);   // no carry into the high half
        write_reg(clint_pkg::OFF_MTIME_LO, 32'(base_v), 4'hf);
        t0 = cycles;
        write_reg(clint_pkg::OFF_MTIME_HI, 0, 4'hf);
        repeat ($urandom_range(60, 20)) next_cycle();
        axi_read(reg_addr(clint_pkg::OFF_MTIME_LO), 0, d, r);
        elapsed = cycles - t0;
        check("mtime resp", 32'(clint_pkg::RESP_OKAY), 32'(r));
        lo_b = base_v + (elapsed - 8) / TICK;
        hi_b = base_v + (elapsed + 8) / TICK;
        if (int'(d) < lo_b || int'(d) > hi_b) begin
            abort_run($sformatf("FAIL mtime count: expected %0d to %0d, actual %0d",
                                lo_b, hi_b, int'(d)));
        end
    endtask

    task automatic timer_interrupt;
        int n;
        write_reg(clint_pkg::OFF_MTIME_HI, 0, 4'hf);
        write_reg(clint_pkg::OFF_MTIME_LO, 0, 4'hf);
        write_reg(clint_pkg::OFF_MTIMECMP_LO, 10, 4'hf);
        write_reg(clint_pkg::OFF_MTIMECMP_HI, 0, 4'hf);
        check("timer_irq before match", 0, 32'(timer_irq));
        for (n = 0; !timer_irq; n++) begin
            if (n == 80) abort_run("timer_irq did not rise within 80 cycles");
            next_cycle();
        end
        write_reg(clint_pkg::OFF_MTIMECMP_HI, 32'hffff_ffff, 4'hf);
        for (n = 0; timer_irq; n++) begin
            if (n == 4) abort_run("timer_irq did not fall after raising mtimecmp");
            next_cycle();
        end
    endtask

    task automatic error_responses;
        logic [31:0] d;
        logic [1:0]  r;
        axi_read(reg_addr(16'h0100), 0, d, r);
        check("unmapped read resp", 32'(clint_pkg::RESP_SLVERR), 32'(r));
        check("unmapped read data", 0, d);
        axi_read(BASE + 32'd2, 0, d, r);
        check("misaligned read resp", 32'(clint_pkg::RESP_SLVERR), 32'(r));
        check("misaligned read data", 0, d);
        axi_read(32'h1000_0000, 0, d, r);
        check("outside read resp", 32'(clint_pkg::RESP_DECERR), 32'(r));
        check("outside read data", 0, d);
        axi_write(reg_addr(16'h0100), 1, 4'hf, 0, r);
        check("unmapped write resp", 32'(clint_pkg::RESP_SLVERR), 32'(r));
        axi_write(BASE + 32'd2, 1, 4'hf, 0, r);   // lands next to msip
        check("misaligned write resp", 32'(clint_pkg::RESP_SLVERR), 32'(r));
        axi_write(32'h1000_0000, 1, 4'hf, 0, r);
        check("outside write resp", 32'(clint_pkg::RESP_DECERR), 32'(r));
        read_expect("msip after bad writes", clint_pkg::OFF_MSIP, 0);
        check("soft_irq after bad writes", 0, 32'(soft_irq));
    endtask

    task automatic backpressure;
        logic [31:0] d;
        logic [1:0]  r;
        logic [31:0] pat;
        pat = $urandom;
        write_reg(clint_pkg::OFF_MTIMECMP_LO, pat, 4'hf);
        axi_read(reg_addr(clint_pkg::OFF_MTIMECMP_LO), $urandom_range(10, 1), d, r);
        check("stalled read resp", 32'(clint_pkg::RESP_OKAY), 32'(r));
        check("stalled read data", pat, d);
        axi_write(reg_addr(clint_pkg::OFF_MSIP), 1, 4'hf, $urandom_range(10, 1), r);
        check("stalled write resp", 32'(clint_pkg::RESP_OKAY), 32'(r));
        read_expect("msip after stall", clint_pkg::OFF_MSIP, 1);
        write_reg(clint_pkg::OFF_MSIP, 0, 4'hf);
    endtask

    initial begin
        void'($urandom(99599));
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_state();
        msip_and_strobes();
        mtime_counting();
        timer_interrupt();
        error_responses();
        backpressure();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/clint_pkg.sv
verilog/clint_axil_front.sv
verilog/clint_decode.sv
verilog/clint_exec.sv
verilog/clint_result.sv
verilog/clint_top.sv
testbench/clint_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module clint_tb -f src.f -o clint_sim

out=$(./obj_dir/clint_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Regression passed'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
